// ==== mtx_macros.svh ====
`ifndef MTX_MACROS_SVH
`define MTX_MACROS_SVH

// Element width in bits
`define MTX_DATA_WIDTH 8

// Square tile side in elements
`define MTX_TILE_DIM 2

// Matrix size counted in tiles
`define MTX_TILE_ROWS 2
`define MTX_TILE_COLS 3

// One tile word, DIM*DIM elements
`define MTX_TILE_BITS 32

`endif

// ==== mtx_pkg.sv ====
`include "mtx_macros.svh"

package mtx_pkg;

  typedef enum logic {
    OP_PASS      = 1'b0,
    OP_TRANSPOSE = 1'b1
  } mtx_op_e;

  // Same tile word seen flat for storage or per element for the transpose
  // Element order is row-major, elem[0] is the top-left element
  typedef union packed {
    logic [`MTX_TILE_BITS-1:0] flat;
    logic [`MTX_TILE_DIM*`MTX_TILE_DIM-1:0][`MTX_DATA_WIDTH-1:0] elem;
  } tile_u;

  // Tile tagged with the op of the matrix it belongs to
  typedef struct packed {
    mtx_op_e mode;
    tile_u   tile;
  } tagged_tile_t;

endpackage

// ==== tile_if.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

interface tile_if;

  mtx_pkg::tagged_tile_t data;
  // Tile column on the input side of the matrix
  logic [$clog2(`MTX_TILE_COLS)-1:0] col;
  logic valid;
  logic ready;

  modport src (
    output data,
    output col,
    output valid,
    input  ready
  );

  modport dst (
    input  data,
    input  col,
    input  valid,
    output ready
  );

endinterface

// ==== tile_fifo.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

module tile_fifo #(
  parameter int DEPTH = `MTX_TILE_ROWS,
  parameter int WIDTH = `MTX_TILE_BITS
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             wr_valid,
  output logic             wr_ready,
  output logic [WIDTH-1:0] rd_data,
  output logic             rd_valid,
  input  logic             rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  assign wr_ready = (count != CNT_W'(DEPTH));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];

  assign wr_en = wr_valid & wr_ready;
  assign rd_en = rd_valid & rd_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous read and write keeps the count
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== mtx_cmd_decode.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

module mtx_cmd_decode (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmd_valid,
  input  mtx_pkg::mtx_op_e          cmd_op,
  output logic                      cmd_ready,
  input  logic [`MTX_TILE_BITS-1:0] in_data,
  input  logic                      in_valid,
  output logic                      in_ready,
  tile_if.src                       tiles
);

  localparam int ROW_W = ($clog2(`MTX_TILE_ROWS) > 0) ? $clog2(`MTX_TILE_ROWS) : 1;
  localparam int COL_W = $clog2(`MTX_TILE_COLS);

  logic             active;
  mtx_pkg::mtx_op_e op_q;
  logic [ROW_W-1:0] row_cnt;
  logic [COL_W-1:0] col_cnt;
  logic             tile_hs;
  logic             last_col;
  logic             last_tile;

  // Only one matrix is taken at a time
  assign cmd_ready = ~active;

  // Input is paced by the command and by the column FIFO downstream
  assign in_ready    = active & tiles.ready;
  assign tiles.valid = active & in_valid;
  assign tiles.col   = col_cnt;

  always_comb begin
    tiles.data.mode      = op_q;
    tiles.data.tile.flat = in_data;
  end

  assign tile_hs   = in_valid & in_ready;
  assign last_col  = (col_cnt == COL_W'(`MTX_TILE_COLS - 1));
  assign last_tile = last_col & (row_cnt == ROW_W'(`MTX_TILE_ROWS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active  <= 1'b0;
      op_q    <= mtx_pkg::OP_PASS;
      row_cnt <= '0;
      col_cnt <= '0;
    end else begin
      if (cmd_valid && cmd_ready) begin
        active <= 1'b1;
        op_q   <= cmd_op;
      end
      // Row-major walk over the input tiles
      if (tile_hs) begin
        if (last_col) begin
          col_cnt <= '0;
          if (last_tile) begin
            row_cnt <= '0;
            active  <= 1'b0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== mtx_stream_transpose.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

module mtx_stream_transpose (
  input  logic clk,
  input  logic rst,
  tile_if.dst  tiles_in,
  tile_if.src  tiles_out
);

  localparam int NUM_COLS = `MTX_TILE_COLS;
  localparam int DIM      = `MTX_TILE_DIM;
  localparam int MAX_DIM  = (`MTX_TILE_COLS > `MTX_TILE_ROWS) ? `MTX_TILE_COLS : `MTX_TILE_ROWS;
  localparam int CNT_W    = ($clog2(MAX_DIM) > 0) ? $clog2(MAX_DIM) : 1;
  localparam int TAG_W    = $bits(mtx_pkg::tagged_tile_t);

  logic                  fifo_wr_valid [NUM_COLS];
  logic                  fifo_wr_ready [NUM_COLS];
  logic                  fifo_rd_valid [NUM_COLS];
  logic                  fifo_rd_ready [NUM_COLS];
  mtx_pkg::tagged_tile_t fifo_rd_data  [NUM_COLS];

  logic [CNT_W-1:0]      out_row;
  logic [CNT_W-1:0]      out_col;
  logic [CNT_W-1:0]      row_last;
  logic [CNT_W-1:0]      col_last;
  logic [CNT_W-1:0]      sel;
  mtx_pkg::mtx_op_e      mode_q;
  mtx_pkg::mtx_op_e      cur_mode;
  mtx_pkg::tagged_tile_t head;
  mtx_pkg::tile_u        out_tile;
  logic                  at_start;
  logic                  rd_hs;

  // One FIFO per input tile column, deep enough for a full column
  for (genvar i = 0; i < NUM_COLS; i++) begin : g_col
    assign fifo_wr_valid[i] = tiles_in.valid && (int'(tiles_in.col) == i);
    assign fifo_rd_ready[i] = tiles_out.ready && (int'(sel) == i);

    tile_fifo #(
      .DEPTH (`MTX_TILE_ROWS),
      .WIDTH (TAG_W)
    ) u_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr_data  (tiles_in.data),
      .wr_valid (fifo_wr_valid[i]),
      .wr_ready (fifo_wr_ready[i]),
      .rd_data  (fifo_rd_data[i]),
      .rd_valid (fifo_rd_valid[i]),
      .rd_ready (fifo_rd_ready[i])
    );
  end

  assign tiles_in.ready = fifo_wr_ready[tiles_in.col];

  // First tile of a matrix always sits at the head of FIFO 0
  assign at_start = (out_row == '0) && (out_col == '0);
  assign cur_mode = at_start ? fifo_rd_data[0].mode : mode_q;

  // Output geometry and FIFO select follow the mode
  always_comb begin
    if (cur_mode == mtx_pkg::OP_TRANSPOSE) begin
      row_last = CNT_W'(`MTX_TILE_COLS - 1);
      col_last = CNT_W'(`MTX_TILE_ROWS - 1);
      sel      = out_row;
    end else begin
      row_last = CNT_W'(`MTX_TILE_ROWS - 1);
      col_last = CNT_W'(`MTX_TILE_COLS - 1);
      sel      = out_col;
    end
  end

  assign tiles_out.valid = fifo_rd_valid[sel];
  assign tiles_out.col   = '0;
  assign rd_hs           = tiles_out.valid & tiles_out.ready;

  // Swap elements across the tile diagonal
  always_comb begin
    head     = fifo_rd_data[sel];
    out_tile = head.tile;
    if (cur_mode == mtx_pkg::OP_TRANSPOSE) begin
      for (int r = 0; r < DIM; r++) begin
        for (int c = 0; c < DIM; c++) begin
          out_tile.elem[r*DIM+c] = head.tile.elem[c*DIM+r];
        end
      end
    end
    tiles_out.data.mode = cur_mode;
    tiles_out.data.tile = out_tile;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_row <= '0;
      out_col <= '0;
      mode_q  <= mtx_pkg::OP_PASS;
    end else if (rd_hs) begin
      if (at_start) begin
        mode_q <= cur_mode;
      end
      // Wraps after the last of the 6 tiles
      if (out_col == col_last) begin
        out_col <= '0;
        out_row <= (out_row == row_last) ? '0 : out_row + 1'b1;
      end else begin
        out_col <= out_col + 1'b1;
      end
    end
  end

endmodule

// ==== mtx_result.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

module mtx_result (
  input  logic                      clk,
  input  logic                      rst,
  tile_if.dst                       tiles,
  output logic [`MTX_TILE_BITS-1:0] out_data,
  output logic                      out_last,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [7:0]                matrix_count
);

  localparam int TILES = `MTX_TILE_ROWS * `MTX_TILE_COLS;
  localparam int CNT_W = $clog2(TILES);

  logic [`MTX_TILE_BITS-1:0] skid_data;
  logic                      skid_valid;
  logic [CNT_W-1:0]          tile_cnt;
  logic                      in_hs;
  logic                      out_hs;
  logic                      load_main;

  // Ready only depends on the skid register, so it is registered too
  assign tiles.ready = ~skid_valid;
  assign in_hs       = tiles.valid & tiles.ready;
  assign out_hs      = out_valid & out_ready;
  assign load_main   = ~out_valid | out_ready;

  assign out_last = out_valid && (tile_cnt == CNT_W'(TILES - 1));

  always_ff @(posedge clk) begin
    if (load_main) begin
      out_data <= skid_valid ? skid_data : tiles.data.tile.flat;
    end else if (in_hs) begin
      skid_data <= tiles.data.tile.flat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid    <= 1'b0;
      skid_valid   <= 1'b0;
      tile_cnt     <= '0;
      matrix_count <= '0;
    end else begin
      // Skid entry drains first, else the main register takes new input
      if (load_main) begin
        out_valid  <= skid_valid | in_hs;
        skid_valid <= 1'b0;
      end else if (in_hs) begin
        skid_valid <= 1'b1;
      end
      if (out_hs) begin
        tile_cnt <= out_last ? '0 : tile_cnt + 1'b1;
        if (out_last) begin
          matrix_count <= matrix_count + 1'b1;
        end
      end
    end
  end

endmodule

// ==== mtx_stream_top.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

module mtx_stream_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmd_valid,
  input  mtx_pkg::mtx_op_e          cmd_op,
  output logic                      cmd_ready,
  input  logic [`MTX_TILE_BITS-1:0] in_data,
  input  logic                      in_valid,
  output logic                      in_ready,
  output logic [`MTX_TILE_BITS-1:0] out_data,
  output logic                      out_last,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [7:0]                matrix_count
);

  tile_if dec_to_exe ();
  tile_if exe_to_res ();

  mtx_cmd_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_ready (cmd_ready),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .tiles     (dec_to_exe.src)
  );

  mtx_stream_transpose u_transpose (
    .clk       (clk),
    .rst       (rst),
    .tiles_in  (dec_to_exe.dst),
    .tiles_out (exe_to_res.src)
  );

  mtx_result u_result (
    .clk          (clk),
    .rst          (rst),
    .tiles        (exe_to_res.dst),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .matrix_count (matrix_count)
  );

endmodule

// ==== mtx_stream_sva.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

module mtx_stream_sva (
  input logic                      clk,
  input logic                      rst,
  input logic                      cmd_ready,
  input logic                      in_ready,
  input logic [`MTX_TILE_BITS-1:0] out_data,
  input logic                      out_last,
  input logic                      out_valid,
  input logic                      out_ready
);

  // Output holds while the sink stalls
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else $error("out_data or out_last changed while out_valid waited for out_ready");

  // Tiles are only taken inside a command
  a_in_gated: assert property (@(posedge clk) disable iff (rst)
    !(in_ready && cmd_ready))
    else $error("in_ready high while no command is active");

  a_reset_idle: assert property (@(posedge clk)
    $fell(rst) |-> !out_valid && !out_last && !in_ready)
    else $error("outputs not idle in the cycle after reset");

endmodule

bind mtx_stream_top mtx_stream_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .cmd_ready (cmd_ready),
  .in_ready  (in_ready),
  .out_data  (out_data),
  .out_last  (out_last),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

// ==== tb_mtx_stream.sv ====
`timescale 1ns/10ps
`include "mtx_macros.svh"

module tb_mtx_stream;

  localparam int TILES        = `MTX_TILE_ROWS * `MTX_TILE_COLS;
  localparam int NUM_MATRICES = 10;
  localparam int MAX_CYCLES   = 40 * NUM_MATRICES + 200;

  logic                      clk;
  logic                      rst;
  logic                      cmd_valid;
  mtx_pkg::mtx_op_e          cmd_op;
  logic                      cmd_ready;
  logic [`MTX_TILE_BITS-1:0] in_data;
  logic                      in_valid;
  logic                      in_ready;
  logic [`MTX_TILE_BITS-1:0] out_data;
  logic                      out_last;
  logic                      out_valid;
  logic                      out_ready;
  logic [7:0]                matrix_count;

  // Expected tile with the last flag in the top bit
  logic [`MTX_TILE_BITS:0]   exp_q [$];
  logic [`MTX_TILE_BITS:0]   exp_tile;
  logic                      stall_en;
  int                        errors;
  int                        errs;
  int                        tests_ok;
  int                        tests_bad;
  int                        sent;
  int                        cycles;

  mtx_stream_top u_mtx_stream_top (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_ready    (cmd_ready),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .matrix_count (matrix_count)
  );

  always #20 clk = ~clk;

  // 2x2 tile transpose swaps the two off-diagonal elements
  function automatic logic [`MTX_TILE_BITS-1:0] swap_diag(input logic [`MTX_TILE_BITS-1:0] t);
    return {t[31:24], t[15:8], t[23:16], t[7:0]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic send_matrix(input mtx_pkg::mtx_op_e op, input int pre_cycles);
    logic [`MTX_TILE_BITS-1:0] tiles [TILES];
    int                        src;
    for (int i = 0; i < TILES; i++) begin
      tiles[i] = $urandom();
    end
    for (int k = 0; k < TILES; k++) begin
      if (op == mtx_pkg::OP_TRANSPOSE) begin
        // Output tile (r, c) of the 3x2 grid is input tile (c, r)
        src = (k % `MTX_TILE_ROWS) * `MTX_TILE_COLS + k / `MTX_TILE_ROWS;
        exp_q.push_back({k == TILES - 1, swap_diag(tiles[src])});
      end else begin
        exp_q.push_back({k == TILES - 1, tiles[k]});
      end
    end
    // First tile offered early must wait for the command
    if (pre_cycles > 0) begin
      in_data  <= tiles[0];
      in_valid <= 1'b1;
      repeat (pre_cycles) begin
        @(posedge clk);
        check_val("in_ready", 0, in_ready);
      end
    end
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    @(posedge clk);
    while (!cmd_ready) @(posedge clk);
    cmd_valid <= 1'b0;
    for (int i = 0; i < TILES; i++) begin
      in_data  <= tiles[i];
      in_valid <= 1'b1;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
    end
    in_valid <= 1'b0;
    sent++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
    check_val("matrix_count", sent, matrix_count);
    if (errors == errs_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: FAILED", name);
    end
  endtask

  // Sink side, random stalls only while enabled
  always @(posedge clk) begin
    if (stall_en) begin
      out_ready <= ($urandom() % 3) != 0;
    end else begin
      out_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output tile %h at %0t ns arrived with none expected", out_data, $time);
        errors++;
      end else begin
        exp_tile = exp_q.pop_front();
        check_val("out_data", exp_tile[`MTX_TILE_BITS-1:0], out_data);
        check_val("out_last", exp_tile[`MTX_TILE_BITS], out_last);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timed out after %0d cycles before all output tiles arrived", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(1870));
    clk       = 1'b0;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = mtx_pkg::OP_PASS;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    stall_en  = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    errs = errors;
    @(posedge clk);
    check_val("cmd_ready", 1, cmd_ready);
    check_val("in_ready", 0, in_ready);
    check_val("out_valid", 0, out_valid);
    check_val("out_last", 0, out_last);
    finish_test("Test 1 reset state", errs);

    errs = errors;
    send_matrix(mtx_pkg::OP_TRANSPOSE, 0);
    finish_test("Test 2 transpose one matrix", errs);

    errs = errors;
    send_matrix(mtx_pkg::OP_PASS, 0);
    finish_test("Test 3 pass one matrix", errs);

    // Next matrix enters while the previous one drains
    errs = errors;
    send_matrix(mtx_pkg::OP_TRANSPOSE, 0);
    send_matrix(mtx_pkg::OP_PASS, 0);
    send_matrix(mtx_pkg::OP_TRANSPOSE, 0);
    send_matrix(mtx_pkg::OP_PASS, 0);
    finish_test("Test 4 alternating overlapped matrices", errs);

    errs = errors;
    stall_en <= 1'b1;
    send_matrix(mtx_pkg::OP_TRANSPOSE, 0);
    send_matrix(mtx_pkg::OP_PASS, 0);
    send_matrix(mtx_pkg::OP_TRANSPOSE, 0);
    finish_test("Test 5 output back-pressure", errs);
    stall_en <= 1'b0;

    errs = errors;
    send_matrix(mtx_pkg::OP_PASS, 4);
    finish_test("Test 6 tiles held before command", errs);

    $display("Tests: %0d ok, %0d failed, %0d check errors", tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
mtx_pkg.sv
tile_if.sv
tile_fifo.sv
mtx_cmd_decode.sv
mtx_stream_transpose.sv
mtx_result.sv
mtx_stream_top.sv
mtx_stream_sva.sv
tb_mtx_stream.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mtx_stream \
  -f files.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
else
  exit 1
fi
